/* filelist.f */
+incdir+.
timer16Pkg.sv
timer16Regs.sv
timer16Counter.sv
timer16Compare.sv
timer16Irq.sv
timer16Top.sv
timer16Tb.sv

/* timer16Tb.sv */
`timescale 1ns/1ps
`include "timer16_macros.svh"

module timer16Tb;
	localparam logic [31:0] seedValue = 32'h48b0_ccf3;
	localparam timer16Pkg::irqVec_t tovSel = 3'b001;
	localparam timer16Pkg::irqVec_t ocfASel = 3'b010;

	logic cp2;
	logic ireset;
	logic tick;
	timer16Pkg::apbReq_t apbReq;
	timer16Pkg::apbRsp_t apbRsp;
	logic ocA;
	logic ocAEn;
	logic ocB;
	logic ocBEn;
	timer16Pkg::irqVec_t irq;

	// Reference model state
	logic [15:0] mCount;
	logic [15:0] mBufA;
	logic [15:0] mBufB;
	logic [15:0] mActA;
	logic [15:0] mActB;
	logic [3:0] mWgm;
	logic mRun;
	logic [1:0] mComA;
	logic [1:0] mComB;
	logic [7:0] mLatch;
	logic mOcA;
	logic mOcB;
	timer16Pkg::irqVec_t mFlags;
	timer16Pkg::irqVec_t mMask;

	int valErrs;
	int otherErrs;
	int tickRate;   // 0 low, 1 random, 2 high
	logic monOn;
	logic [15:0] sampledCount;

	timer16Top uut (
		.cp2(cp2), .ireset(ireset), .apbReq(apbReq), .apbRsp(apbRsp), .tick(tick),
		.ocA(ocA), .ocAEn(ocAEn), .ocB(ocB), .ocBEn(ocBEn), .irq(irq)
	);

	initial begin
		cp2 = 1'b0;
		forever #10 cp2 = ~cp2;
	end

	task automatic checkByte(input string name, input logic [7:0] expVal,
		input logic [7:0] actVal);
		if (actVal !== expVal) begin
			valErrs++;
			$display("ERR %0t %s expected %h got %h", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkWord(input string name, input logic [15:0] expVal,
		input logic [15:0] actVal);
		if (actVal !== expVal) begin
			valErrs++;
			$display("ERR %0t %s expected %h got %h", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkIrq(input string name, input timer16Pkg::irqVec_t expVal,
		input timer16Pkg::irqVec_t actVal);
		if (actVal !== expVal) begin
			valErrs++;
			$display("ERR %0t %s expected %b got %b", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkPin(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			valErrs++;
			$display("ERR %0t %s expected %b got %b", $time, name, expVal, actVal);
		end
	endtask

	// Next output pin state of one compare channel
	function automatic logic ocNext(input logic oc, input logic [1:0] com, input logic pwm,
		input logic act, input logic hit, input logic bottom);
		if (com == 2'b00 || (pwm && com == 2'b01))
			return 1'b0;
		if (!act)
			return oc;
		if (!pwm) begin
			if (!hit)
				return oc;
			case (com)
				2'b01: return ~oc;
				2'b10: return 1'b0;
				default: return 1'b1;
			endcase
		end
		if (hit)
			return com == 2'b11;
		if (bottom)
			return com == 2'b10;
		return oc;
	endfunction

	function automatic logic [15:0] activeNext(input logic [15:0] act, input logic [15:0] bufVal,
		input logic pwm, input logic wr, input logic [15:0] wrVal, input logic stepOk,
		input logic bottom);
		if (!pwm && wr)
			return wrVal;
		if (pwm && stepOk && bottom)
			return bufVal;   // Double buffer reload at bottom
		return act;
	endfunction

	function automatic logic [7:0] modelRead(input logic [`TMR_ADDR_W-1:0] addr);
		case (addr)
			`TMR_TCCRA: return {mComA, mComB, 2'b00, mWgm[1:0]};
			`TMR_TCCRB: return {3'b000, mWgm[3:2], 2'b00, mRun};
			`TMR_TCNTL: return mCount[7:0];
			`TMR_TCNTH: return mLatch;
			`TMR_OCRAL: return mBufA[7:0];
			`TMR_OCRAH: return mBufA[15:8];
			`TMR_OCRBL: return mBufB[7:0];
			`TMR_OCRBH: return mBufB[15:8];
			`TMR_TIFR: return {5'b00000, mFlags};
			`TMR_TIMSK: return {5'b00000, mMask};
			default: return 8'h00;
		endcase
	endfunction

	function automatic logic isMapped(input logic [`TMR_ADDR_W-1:0] addr);
		case (addr)
			`TMR_TCCRA, `TMR_TCCRB, `TMR_TCNTL, `TMR_TCNTH, `TMR_OCRAL, `TMR_OCRAH,
			`TMR_OCRBL, `TMR_OCRBH, `TMR_TIFR, `TMR_TIMSK: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	always @(posedge cp2 or negedge ireset) begin : refModel
		logic wrAcc;
		logic rdAcc;
		logic load;
		logic modeOk;
		logic pwm;
		logic stepCyc;
		logic adv;
		logic [15:0] top;
		logic [15:0] wrVal;
		timer16Pkg::irqVec_t setEv;
		timer16Pkg::irqVec_t clr;
		if (!ireset) begin
			mCount <= '0;
			mBufA <= '0;
			mBufB <= '0;
			mActA <= '0;
			mActB <= '0;
			mWgm <= '0;
			mRun <= 1'b0;
			mComA <= '0;
			mComB <= '0;
			mLatch <= '0;
			mOcA <= 1'b0;
			mOcB <= 1'b0;
			mFlags <= '0;
			mMask <= '0;
		end else begin
			wrAcc = apbReq.psel & apbReq.penable & apbReq.pwrite;
			rdAcc = apbReq.psel & apbReq.penable & ~apbReq.pwrite;
			wrVal = {mLatch, apbReq.pwdata};
			load = wrAcc && apbReq.paddr == `TMR_TCNTL;
			modeOk = 1'b1;
			pwm = 1'b0;
			top = 16'hFFFF;
			case (mWgm)
				`TMR_WGM_NORMAL: top = 16'hFFFF;
				`TMR_WGM_CTC: top = mActA;
				`TMR_WGM_PWM8: begin
					top = 16'h00FF;
					pwm = 1'b1;
				end
				`TMR_WGM_PWM10: begin
					top = 16'h03FF;
					pwm = 1'b1;
				end
				default: modeOk = 1'b0;
			endcase
			stepCyc = mRun & tick & modeOk;
			adv = stepCyc & ~load;
			setEv.tov = adv & (pwm ? mCount == top : mCount == 16'hFFFF);
			setEv.ocfA = stepCyc & (mCount == mActA);   // Loads do not hide matches
			setEv.ocfB = stepCyc & (mCount == mActB);
			clr = '0;
			if (wrAcc && apbReq.paddr == `TMR_TIFR)
				clr = timer16Pkg::irqVec_t'(apbReq.pwdata[2:0]);
			mFlags <= timer16Pkg::irqVec_t'((mFlags & ~clr) | (~mFlags & setEv));
			if (load)
				mCount <= wrVal;
			else if (adv)
				mCount <= (mCount == top) ? 16'h0000 : mCount + 16'h0001;
			mOcA <= ocNext(mOcA, mComA, pwm, adv, mCount == mActA, mCount == 16'h0000);
			mOcB <= ocNext(mOcB, mComB, pwm, adv, mCount == mActB, mCount == 16'h0000);
			mActA <= activeNext(mActA, mBufA, pwm, wrAcc && apbReq.paddr == `TMR_OCRAL, wrVal,
				adv, mCount == 16'h0000);
			mActB <= activeNext(mActB, mBufB, pwm, wrAcc && apbReq.paddr == `TMR_OCRBL, wrVal,
				adv, mCount == 16'h0000);
			if (wrAcc && apbReq.paddr == `TMR_OCRAL)
				mBufA <= wrVal;
			if (wrAcc && apbReq.paddr == `TMR_OCRBL)
				mBufB <= wrVal;
			if (rdAcc && apbReq.paddr == `TMR_TCNTL)
				mLatch <= mCount[15:8];
			else if (wrAcc && (apbReq.paddr == `TMR_TCNTH || apbReq.paddr == `TMR_OCRAH ||
					apbReq.paddr == `TMR_OCRBH))
				mLatch <= apbReq.pwdata;
			if (wrAcc && apbReq.paddr == `TMR_TCCRA) begin
				mComA <= apbReq.pwdata[`TMR_COMA_MSB:`TMR_COMA_LSB];
				mComB <= apbReq.pwdata[`TMR_COMB_MSB:`TMR_COMB_LSB];
				mWgm[1:0] <= apbReq.pwdata[`TMR_WGML_MSB:`TMR_WGML_LSB];
			end
			if (wrAcc && apbReq.paddr == `TMR_TCCRB) begin
				mWgm[3:2] <= apbReq.pwdata[`TMR_WGMH_MSB:`TMR_WGMH_LSB];
				mRun <= apbReq.pwdata[`TMR_BIT_RUN];
			end
			if (wrAcc && apbReq.paddr == `TMR_TIMSK)
				mMask <= timer16Pkg::irqVec_t'(apbReq.pwdata[2:0]);
		end
	end

	// Pins and internal compare values every cycle
	always @(negedge cp2) begin
		if (ireset && monOn) begin
			checkPin("ocA", mOcA, ocA);
			checkPin("ocB", mOcB, ocB);
			checkPin("ocAEn", mComA != 2'b00, ocAEn);
			checkPin("ocBEn", mComB != 2'b00, ocBEn);
			checkPin("pready", 1'b1, apbRsp.pready);
			checkIrq("irq", timer16Pkg::irqVec_t'(mFlags & mMask), irq);
			checkWord("ocrActiveA", mActA, uut.cmpA.ocrActive);
			checkWord("ocrActiveB", mActB, uut.cmpB.ocrActive);
			if (!(apbReq.psel && apbReq.penable && !apbReq.pwrite))
				checkByte("prdata", 8'h00, apbRsp.prdata);
			if (!(apbReq.psel && apbReq.penable))
				checkPin("pslverr", 1'b0, apbRsp.pslverr);
		end
	end

	task automatic finishRun();
		$display("Errors: %0d value mismatches, %0d other failures", valErrs, otherErrs);
		if (valErrs == 0 && otherErrs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	task automatic failTimeout(input string what);
		otherErrs++;
		$display("Timeout while %s", what);
		finishRun();
	endtask

	task automatic nextCycle();
		@(posedge cp2);
		#2;
		case (tickRate)
			0: tick = 1'b0;
			1: tick = $urandom_range(0, 1);
			default: tick = 1'b1;
		endcase
	endtask

	task automatic runCycles(input int n);
		repeat (n) nextCycle();
	endtask

	// One APB transfer with the response checked in the access cycle
	task automatic apbAccess(input logic [`TMR_ADDR_W-1:0] addr, input logic wr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int n;
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = wr;
		apbReq.paddr = addr;
		apbReq.pwdata = wr ? wdata : 8'h00;
		nextCycle();
		apbReq.penable = 1'b1;
		n = 0;
		@(negedge cp2);
		while (apbRsp.pready !== 1'b1 && n < 8) begin
			@(negedge cp2);
			n++;
		end
		if (apbRsp.pready !== 1'b1)
			failTimeout("waiting for pready");
		checkByte($sformatf("prdata[%h]", addr), wr ? 8'h00 : modelRead(addr), apbRsp.prdata);
		checkPin($sformatf("pslverr[%h]", addr), ~isMapped(addr), apbRsp.pslverr);
		sampledCount = mCount;
		rdata = apbRsp.prdata;
		nextCycle();
		apbReq.psel = 1'b0;
		apbReq.penable = 1'b0;
		apbReq.pwrite = 1'b0;
	endtask

	task automatic writeReg(input logic [`TMR_ADDR_W-1:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		apbAccess(addr, 1'b1, data, unused);
	endtask

	task automatic readReg(input logic [`TMR_ADDR_W-1:0] addr, output logic [7:0] data);
		apbAccess(addr, 1'b0, 8'h00, data);
	endtask

	task automatic writeWord(input logic [`TMR_ADDR_W-1:0] hiAddr,
		input logic [`TMR_ADDR_W-1:0] loAddr, input logic [15:0] value);
		writeReg(hiAddr, value[15:8]);
		writeReg(loAddr, value[7:0]);
	endtask

	// Low byte first so the high byte is latched
	task automatic readCount(output logic [15:0] value);
		logic [7:0] lo;
		logic [7:0] hi;
		logic [15:0] expCount;
		readReg(`TMR_TCNTL, lo);
		expCount = sampledCount;
		readReg(`TMR_TCNTH, hi);
		value = {hi, lo};
		checkWord("TCNT", expCount, value);
	endtask

	task automatic waitIrq(input timer16Pkg::irqVec_t sel, input int limit, input string what);
		int n;
		logic [15:0] cnt;
		n = 0;
		while ((irq & sel) == 3'b000 && n < limit) begin
			readCount(cnt);
			n++;
		end
		if ((irq & sel) == 3'b000)
			failTimeout(what);
	endtask

	initial begin : stimulus
		logic [31:0] rnd;
		logic [15:0] valA;
		logic [15:0] valB;
		logic [15:0] word;
		logic [15:0] lastCnt;
		logic [7:0] data;
		logic [7:0] hi;
		logic [1:0] comA;
		logic [1:0] comB;
		logic prevOc;
		logic sawWrap;
		rnd = $urandom(seedValue);
		ireset = 1'b0;
		tick = 1'b0;
		apbReq = '0;
		tickRate = 0;
		valErrs = 0;
		otherErrs = 0;
		monOn = 1'b0;
		sampledCount = '0;
		repeat (10) @(posedge cp2);
		#2;
		ireset = 1'b1;
		monOn = 1'b1;

		// Reset values over the whole offset range
		for (int a = 0; a < 16; a++)
			readReg(a[3:0], data);
		checkIrq("irq after reset", 3'b000, irq);

		rnd = $urandom;
		valA = rnd[15:0];
		valB = rnd[31:16];
		writeWord(`TMR_OCRAH, `TMR_OCRAL, valA);
		writeWord(`TMR_OCRBH, `TMR_OCRBL, valB);
		readReg(`TMR_OCRAH, hi);
		readReg(`TMR_OCRAL, data);
		checkWord("OCRA", valA, {hi, data});
		readReg(`TMR_OCRBH, hi);
		readReg(`TMR_OCRBL, data);
		checkWord("OCRB", valB, {hi, data});
		writeReg(4'hE, 8'hFF);   // Unmapped offset is ignored
		readReg(4'h3, data);

		// Normal mode wrap through FFFF
		writeReg(`TMR_TIMSK, 8'h01);
		writeWord(`TMR_TCNTH, `TMR_TCNTL, 16'hFFC0 | $urandom_range(0, 63));
		tickRate = 1;
		writeReg(`TMR_TCCRA, 8'h00);
		writeReg(`TMR_TCCRB, 8'h01);
		waitIrq(tovSel, 200, "waiting for TOV in normal mode");
		readCount(word);
		writeReg(`TMR_TIFR, 8'h01);

		// CTC with top at OCRA
		writeReg(`TMR_TCCRB, 8'h00);
		tickRate = 2;
		valA = 16'h0020 + $urandom_range(0, 63);
		writeWord(`TMR_OCRAH, `TMR_OCRAL, valA);
		writeWord(`TMR_TCNTH, `TMR_TCNTL, 16'h0000);
		writeReg(`TMR_TIFR, 8'h07);
		writeReg(`TMR_TIMSK, 8'h02);
		writeReg(`TMR_TCCRB, 8'h09);
		waitIrq(ocfASel, 100, "waiting for OCFA in CTC mode");
		sawWrap = 1'b0;
		lastCnt = 16'h0000;
		repeat (40) begin
			readCount(word);
			if (word > valA) begin
				valErrs++;
				$display("ERR %0t TCNT expected at most %h got %h", $time, valA, word);
			end
			if (word < lastCnt)
				sawWrap = 1'b1;
			lastCnt = word;
		end
		if (!sawWrap) begin
			otherErrs++;
			$display("CTC count never wrapped after reaching OCRA");
		end
		writeReg(`TMR_TCCRB, 8'h08);
		writeReg(`TMR_TIFR, 8'h00);
		readReg(`TMR_TIFR, data);
		checkByte("TIFR.ocfA", 8'h02, data & 8'h02);
		writeReg(`TMR_TIFR, 8'h02);
		readReg(`TMR_TIFR, data);
		checkByte("TIFR.ocfA", 8'h00, data & 8'h02);

		// Three random fast PWM 8-bit setups
		tickRate = 1;
		for (int r = 0; r < 3; r++) begin
			writeReg(`TMR_TCCRB, 8'h00);
			rnd = $urandom;
			comA = rnd[1:0];
			comB = rnd[3:2];
			valA = {8'h00, rnd[15:8]};
			valB = {8'h00, rnd[23:16]};
			word = {8'h00, rnd[31:24]};
			writeWord(`TMR_OCRAH, `TMR_OCRAL, valA);
			writeWord(`TMR_OCRBH, `TMR_OCRBL, valB);
			writeWord(`TMR_TCNTH, `TMR_TCNTL, 16'h0000);
			writeReg(`TMR_TCCRA, {comA, comB, 2'b00, 2'b01});
			writeReg(`TMR_TCCRB, 8'h09);
			runCycles(600);
			writeWord(`TMR_OCRAH, `TMR_OCRAL, word);
			checkWord("ocrActiveA held", valA, uut.cmpA.ocrActive);
			runCycles(1200);
			checkWord("ocrActiveA reloaded", word, uut.cmpA.ocrActive);
		end

		// Toggle on match in normal mode
		writeReg(`TMR_TCCRB, 8'h00);
		tickRate = 0;
		writeReg(`TMR_TCCRA, 8'h40);
		writeReg(`TMR_TIMSK, 8'h02);
		valA = 16'h1000 + $urandom_range(0, 16'h0FFF);
		writeWord(`TMR_OCRAH, `TMR_OCRAL, valA);
		for (int r = 0; r < 3; r++) begin
			writeReg(`TMR_TIFR, 8'h07);
			writeWord(`TMR_TCNTH, `TMR_TCNTL, valA - 16'd6);
			prevOc = mOcA;
			tickRate = 2;
			writeReg(`TMR_TCCRB, 8'h01);
			waitIrq(ocfASel, 50, "waiting for OCFA in toggle mode");
			checkPin("ocA toggled", ~prevOc, ocA);
			tickRate = 0;
			writeReg(`TMR_TCCRB, 8'h00);
		end

		// TCNT load in the match cycle
		writeReg(`TMR_TCCRB, 8'h01);
		writeReg(`TMR_TIFR, 8'h07);
		writeWord(`TMR_TCNTH, `TMR_TCNTL, valA - 16'd1);
		prevOc = mOcA;
		word = valA - 16'd40;
		writeReg(`TMR_TCNTH, word[15:8]);
		tickRate = 2;
		tick = 1'b1;   // Setup cycle steps the count onto OCRA
		writeReg(`TMR_TCNTL, word[7:0]);
		tickRate = 0;
		tick = 1'b0;
		checkPin("ocA blocked", prevOc, ocA);
		readReg(`TMR_TIFR, data);
		checkByte("TIFR.ocfA", 8'h02, data & 8'h02);

		finishRun();
	end

endmodule

/* timer16Top.sv */
`timescale 1ns/1ps
`include "timer16_macros.svh"

module timer16Top (
	input  logic                cp2,
	input  logic                ireset,
	input  timer16Pkg::apbReq_t apbReq,
	output timer16Pkg::apbRsp_t apbRsp,
	input  logic                tick,
	output logic                ocA,
	output logic                ocAEn,
	output logic                ocB,
	output logic                ocBEn,
	output timer16Pkg::irqVec_t irq
);
	timer16Pkg::tmrCtrl_t ctrl;
	timer16Pkg::cntWr_t cntWr;
	timer16Pkg::cntWr_t ocrWrA;
	timer16Pkg::cntWr_t ocrWrB;
	timer16Pkg::irqVec_t flagClr;
	timer16Pkg::irqVec_t mask;
	timer16Pkg::irqVec_t flags;
	timer16Pkg::cntStat_t cntStat;
	logic [`TMR_CNT_W-1:0] ocrBufA;
	logic [`TMR_CNT_W-1:0] ocrBufB;
	logic [`TMR_CNT_W-1:0] ocrActA;   // CTC top
	logic matchA;
	logic matchB;

	timer16Regs regs (
		.cp2(cp2), .ireset(ireset), .apbReq(apbReq), .cntStat(cntStat),
		.ocrBufA(ocrBufA), .ocrBufB(ocrBufB), .flags(flags), .apbRsp(apbRsp),
		.ctrl(ctrl), .cntWr(cntWr), .ocrWrA(ocrWrA), .ocrWrB(ocrWrB),
		.flagClr(flagClr), .mask(mask)
	);

	timer16Counter counter (
		.cp2(cp2), .ireset(ireset), .ctrl(ctrl), .tick(tick), .cntWr(cntWr),
		.ocrA(ocrActA), .cntStat(cntStat)
	);

	timer16Compare cmpA (
		.cp2(cp2), .ireset(ireset), .cntStat(cntStat), .com(ctrl.comA), .ocrWr(ocrWrA),
		.cntWr(cntWr), .ocrBuf(ocrBufA), .ocrActive(ocrActA), .match(matchA),
		.oc(ocA), .ocEn(ocAEn)
	);

	timer16Compare cmpB (
		.cp2(cp2), .ireset(ireset), .cntStat(cntStat), .com(ctrl.comB), .ocrWr(ocrWrB),
		.cntWr(cntWr), .ocrBuf(ocrBufB), .ocrActive(), .match(matchB),
		.oc(ocB), .ocEn(ocBEn)
	);

	timer16Irq irqs (
		.cp2(cp2), .ireset(ireset), .ovf(cntStat.ovf), .matchA(matchA), .matchB(matchB),
		.flagClr(flagClr), .mask(mask), .flags(flags), .irq(irq)
	);

endmodule

/* timer16Irq.sv */
`timescale 1ns/1ps

module timer16Irq (
	input  logic                cp2,
	input  logic                ireset,
	input  logic                ovf,
	input  logic                matchA,
	input  logic                matchB,
	input  timer16Pkg::irqVec_t flagClr,
	input  timer16Pkg::irqVec_t mask,
	output timer16Pkg::irqVec_t flags,
	output timer16Pkg::irqVec_t irq
);
	timer16Pkg::irqVec_t setEv;
	timer16Pkg::irqVec_t flagNext;

	always_comb begin
		setEv.tov = ovf;
		setEv.ocfA = matchA;
		setEv.ocfB = matchB;
	end

	// Set flags only clear on write-one, clear flags only take events
	always_comb begin
		flagNext = timer16Pkg::irqVec_t'((flags & ~flagClr) | (~flags & setEv));
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			flags <= '0;
		end else begin
			flags <= flagNext;
		end
	end

	assign irq = flags & mask;   // Level outputs

endmodule

/* timer16Compare.sv */
`timescale 1ns/1ps
`include "timer16_macros.svh"

module timer16Compare (
	input  logic                  cp2,
	input  logic                  ireset,
	input  timer16Pkg::cntStat_t  cntStat,
	input  logic [1:0]            com,
	input  timer16Pkg::cntWr_t    ocrWr,
	input  timer16Pkg::cntWr_t    cntWr,
	output logic [`TMR_CNT_W-1:0] ocrBuf,
	output logic [`TMR_CNT_W-1:0] ocrActive,
	output logic                  match,
	output logic                  oc,
	output logic                  ocEn
);
	logic hit;
	logic atBottom;
	logic act;
	logic forceLow;

	assign hit = cntStat.count == ocrActive;
	assign atBottom = cntStat.count == '0;
	assign act = cntStat.step & ~cntWr.valid;   // TCNT write blocks the pin update
	assign match = cntStat.step & hit;   // Flag still fires on a blocked cycle
	assign ocEn = com != 2'b00;
	assign forceLow = ~ocEn | (cntStat.pwm & (com == 2'b01));

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ocrBuf <= '0;
		end else if (ocrWr.valid) begin
			ocrBuf <= ocrWr.value;
		end
	end

	// Immediate update in normal and CTC, double-buffered at bottom in PWM
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ocrActive <= '0;
		end else if (!cntStat.pwm && ocrWr.valid) begin
			ocrActive <= ocrWr.value;
		end else if (cntStat.pwm && act && atBottom) begin
			ocrActive <= ocrBuf;
		end
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			oc <= 1'b0;
		end else if (forceLow) begin
			oc <= 1'b0;
		end else if (act) begin
			if (!cntStat.pwm) begin
				if (hit) begin
					case (com)
						2'b01: oc <= ~oc;
						2'b10: oc <= 1'b0;
						default: oc <= 1'b1;
					endcase
				end
			end else if (hit) begin
				oc <= (com == 2'b11);   // Match wins over bottom
			end else if (atBottom) begin
				oc <= (com == 2'b10);
			end
		end
	end

	ocLowWhenOff: assert property (@(posedge cp2) disable iff (!ireset)
		(!ocEn && $past(!ocEn)) |-> !oc);

endmodule

/* timer16Counter.sv */
`timescale 1ns/1ps
`include "timer16_macros.svh"

module timer16Counter (
	input  logic                  cp2,
	input  logic                  ireset,
	input  timer16Pkg::tmrCtrl_t  ctrl,
	input  logic                  tick,
	input  timer16Pkg::cntWr_t    cntWr,
	input  logic [`TMR_CNT_W-1:0] ocrA,
	output timer16Pkg::cntStat_t  cntStat
);
	logic [`TMR_CNT_W-1:0] count;
	logic [`TMR_CNT_W-1:0] top;
	logic modeOk;
	logic pwm;
	logic tickCyc;   // Would-be step, a load may still override it
	logic advance;
	logic ovf;

	always_comb begin
		top = '1;
		modeOk = 1'b1;
		pwm = 1'b0;
		case (ctrl.wgm)
			`TMR_WGM_NORMAL: top = '1;
			`TMR_WGM_CTC: top = ocrA;   // Active OCRA, not the buffer
			`TMR_WGM_PWM8: begin
				top = 16'h00FF;
				pwm = 1'b1;
			end
			`TMR_WGM_PWM10: begin
				top = 16'h03FF;
				pwm = 1'b1;
			end
			default: modeOk = 1'b0;   // Reserved modes hold
		endcase
	end

	assign tickCyc = ctrl.run & tick & modeOk;
	assign advance = tickCyc & ~cntWr.valid;

	// Overflow at top in PWM, at FFFF otherwise
	assign ovf = advance & (pwm ? (count == top) : (count == '1));

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			count <= '0;
		end else if (cntWr.valid) begin
			count <= cntWr.value;
		end else if (advance) begin
			count <= (count == top) ? '0 : count + 1'b1;
		end
	end

	always_comb begin
		cntStat.count = count;
		cntStat.step = tickCyc;
		cntStat.ovf = ovf;
		cntStat.pwm = pwm;
	end

	// Fixed PWM tops, so only a load or a mode change can leave the count above top
	pwmBelowTop: assert property (@(posedge cp2) disable iff (!ireset)
		(pwm && tickCyc && count > top) |->
			$past(cntWr.valid) || $past(ctrl.wgm) != ctrl.wgm || $past(count) > top);

endmodule

/* timer16Regs.sv */
`timescale 1ns/1ps
`include "timer16_macros.svh"

module timer16Regs (
	input  logic                  cp2,
	input  logic                  ireset,
	input  timer16Pkg::apbReq_t   apbReq,
	input  timer16Pkg::cntStat_t  cntStat,
	input  logic [`TMR_CNT_W-1:0] ocrBufA,
	input  logic [`TMR_CNT_W-1:0] ocrBufB,
	input  timer16Pkg::irqVec_t   flags,
	output timer16Pkg::apbRsp_t   apbRsp,
	output timer16Pkg::tmrCtrl_t  ctrl,
	output timer16Pkg::cntWr_t    cntWr,
	output timer16Pkg::cntWr_t    ocrWrA,
	output timer16Pkg::cntWr_t    ocrWrB,
	output timer16Pkg::irqVec_t   flagClr,
	output timer16Pkg::irqVec_t   mask
);
	logic access;
	logic wrAcc;
	logic rdAcc;
	logic mapped;
	logic [`TMR_DATA_W-1:0] hiLatch;   // Shared high byte for 16-bit access
	logic [`TMR_DATA_W-1:0] rdByte;
	timer16Pkg::timerWord_u wrWord;
	timer16Pkg::timerWord_u cntView;
	timer16Pkg::timerWord_u ocrViewA;
	timer16Pkg::timerWord_u ocrViewB;

	assign access = apbReq.psel & apbReq.penable;
	assign wrAcc = access & apbReq.pwrite;
	assign rdAcc = access & ~apbReq.pwrite;

	always_comb begin
		wrWord.bytes.hi = hiLatch;   // Low write completes the word
		wrWord.bytes.lo = apbReq.pwdata;
		cntView.word = cntStat.count;
		ocrViewA.word = ocrBufA;
		ocrViewB.word = ocrBufB;
	end

	always_comb begin
		cntWr.valid = wrAcc & (apbReq.paddr == `TMR_TCNTL);
		cntWr.value = wrWord.word;
		ocrWrA.valid = wrAcc & (apbReq.paddr == `TMR_OCRAL);
		ocrWrA.value = wrWord.word;
		ocrWrB.valid = wrAcc & (apbReq.paddr == `TMR_OCRBL);
		ocrWrB.value = wrWord.word;
		flagClr = '0;
		if (wrAcc && apbReq.paddr == `TMR_TIFR) begin
			flagClr.tov = apbReq.pwdata[`TMR_BIT_TOV];
			flagClr.ocfA = apbReq.pwdata[`TMR_BIT_OCFA];
			flagClr.ocfB = apbReq.pwdata[`TMR_BIT_OCFB];
		end
	end

	// Control and mask registers
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ctrl <= '0;
			mask <= '0;
		end else if (wrAcc) begin
			case (apbReq.paddr)
				`TMR_TCCRA: begin
					ctrl.comA <= apbReq.pwdata[`TMR_COMA_MSB:`TMR_COMA_LSB];
					ctrl.comB <= apbReq.pwdata[`TMR_COMB_MSB:`TMR_COMB_LSB];
					ctrl.wgm[1:0] <= apbReq.pwdata[`TMR_WGML_MSB:`TMR_WGML_LSB];
				end
				`TMR_TCCRB: begin
					ctrl.wgm[3:2] <= apbReq.pwdata[`TMR_WGMH_MSB:`TMR_WGMH_LSB];
					ctrl.run <= apbReq.pwdata[`TMR_BIT_RUN];
				end
				`TMR_TIMSK: begin
					mask.tov <= apbReq.pwdata[`TMR_BIT_TOV];
					mask.ocfA <= apbReq.pwdata[`TMR_BIT_OCFA];
					mask.ocfB <= apbReq.pwdata[`TMR_BIT_OCFB];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			hiLatch <= '0;
		end else if (rdAcc && apbReq.paddr == `TMR_TCNTL) begin
			hiLatch <= cntView.bytes.hi;   // Freeze high half for the TCNTH read
		end else if (wrAcc && (apbReq.paddr == `TMR_TCNTH || apbReq.paddr == `TMR_OCRAH ||
				apbReq.paddr == `TMR_OCRBH)) begin
			hiLatch <= apbReq.pwdata;
		end
	end

	// Readback mux, unimplemented bits stay 0
	always_comb begin
		mapped = 1'b1;
		rdByte = '0;
		case (apbReq.paddr)
			`TMR_TCCRA: begin
				rdByte[`TMR_COMA_MSB:`TMR_COMA_LSB] = ctrl.comA;
				rdByte[`TMR_COMB_MSB:`TMR_COMB_LSB] = ctrl.comB;
				rdByte[`TMR_WGML_MSB:`TMR_WGML_LSB] = ctrl.wgm[1:0];
			end
			`TMR_TCCRB: begin
				rdByte[`TMR_WGMH_MSB:`TMR_WGMH_LSB] = ctrl.wgm[3:2];
				rdByte[`TMR_BIT_RUN] = ctrl.run;
			end
			`TMR_TCNTL: rdByte = cntView.bytes.lo;
			`TMR_TCNTH: rdByte = hiLatch;
			`TMR_OCRAL: rdByte = ocrViewA.bytes.lo;
			`TMR_OCRAH: rdByte = ocrViewA.bytes.hi;
			`TMR_OCRBL: rdByte = ocrViewB.bytes.lo;
			`TMR_OCRBH: rdByte = ocrViewB.bytes.hi;
			`TMR_TIFR: begin
				rdByte[`TMR_BIT_TOV] = flags.tov;
				rdByte[`TMR_BIT_OCFA] = flags.ocfA;
				rdByte[`TMR_BIT_OCFB] = flags.ocfB;
			end
			`TMR_TIMSK: begin
				rdByte[`TMR_BIT_TOV] = mask.tov;
				rdByte[`TMR_BIT_OCFA] = mask.ocfA;
				rdByte[`TMR_BIT_OCFB] = mask.ocfB;
			end
			default: mapped = 1'b0;
		endcase
	end

	always_comb begin
		apbRsp.prdata = rdAcc ? rdByte : '0;
		apbRsp.pready = 1'b1;   // Zero wait states
		apbRsp.pslverr = access & ~mapped;
	end

	prdataIdle: assert property (@(posedge cp2) disable iff (!ireset)
		!(apbReq.psel && apbReq.penable && !apbReq.pwrite) |-> apbRsp.prdata == '0);

	slverrInAccess: assert property (@(posedge cp2) disable iff (!ireset)
		apbRsp.pslverr |-> apbReq.psel && apbReq.penable);

endmodule

/* timer16Pkg.sv */
`include "timer16_macros.svh"

package timer16Pkg;

	// APB master to slave
	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`TMR_ADDR_W-1:0] paddr;
		logic [`TMR_DATA_W-1:0] pwdata;
	} apbReq_t;

	// APB slave to master
	typedef struct packed {
		logic [`TMR_DATA_W-1:0] prdata;
		logic                   pready;
		logic                   pslverr;
	} apbRsp_t;

	// 16-bit register seen as a word or as two bytes
	typedef union packed {
		logic [`TMR_CNT_W-1:0] word;
		struct packed {
			logic [`TMR_DATA_W-1:0] hi;
			logic [`TMR_DATA_W-1:0] lo;
		} bytes;
	} timerWord_u;

	typedef struct packed {
		logic                  valid;
		logic [`TMR_CNT_W-1:0] value;
	} cntWr_t;

	typedef struct packed {
		logic [`TMR_CNT_W-1:0] count;
		logic                  step;   // Tick cycle in a valid mode
		logic                  ovf;
		logic                  pwm;
	} cntStat_t;

	typedef struct packed {
		logic [3:0] wgm;
		logic       run;
		logic [1:0] comA;
		logic [1:0] comB;
	} tmrCtrl_t;

	// Bit order follows TIFR and TIMSK
	typedef struct packed {
		logic ocfB;
		logic ocfA;
		logic tov;
	} irqVec_t;

endpackage

/* timer16_macros.svh */
`ifndef TIMER16_MACROS_SVH
`define TIMER16_MACROS_SVH

// Widths
`define TMR_DATA_W 8
`define TMR_CNT_W 16
`define TMR_ADDR_W 4

// APB register offsets
`define TMR_TCCRA 4'h0
`define TMR_TCCRB 4'h1
`define TMR_TCNTL 4'h4
`define TMR_TCNTH 4'h5
`define TMR_OCRAL 4'h8
`define TMR_OCRAH 4'h9
`define TMR_OCRBL 4'hA
`define TMR_OCRBH 4'hB
`define TMR_TIFR 4'hC
`define TMR_TIMSK 4'hD

// Waveform generation modes
`define TMR_WGM_NORMAL 4'd0
`define TMR_WGM_CTC 4'd4
`define TMR_WGM_PWM8 4'd5
`define TMR_WGM_PWM10 4'd7

// TIFR and TIMSK bits
`define TMR_BIT_TOV 0
`define TMR_BIT_OCFA 1
`define TMR_BIT_OCFB 2

// TCCRB fields
`define TMR_BIT_RUN 0
`define TMR_WGMH_MSB 4
`define TMR_WGMH_LSB 3

// TCCRA fields
`define TMR_COMA_MSB 7
`define TMR_COMA_LSB 6
`define TMR_COMB_MSB 5
`define TMR_COMB_LSB 4
`define TMR_WGML_MSB 1
`define TMR_WGML_LSB 0

`endif
